/* Makefile */
# Verilator build and run for the DUC testbench

VERILATOR ?= verilator
TOP       ?= tb_duc
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* all.f */
+incdir+.
duc_pkg.sv
sample_fifo.sv
dds_sincos.sv
complex_mixer.sv
round_sat.sv
dds_freq_tune_duc.sv
tb_duc.sv

/* complex_mixer.sv */
`default_nettype none

module complex_mixer #(
  parameter int INPUT_W = duc_pkg::INPUT_W,
  parameter int DDS_W   = duc_pkg::DDS_W
) (
  input  wire                 clk,
  input  wire                 i_rst,
  input  wire duc_pkg::iq_beat_t   i_smp,
  input  wire                 i_smp_valid,
  output logic                o_smp_ready,
  input  wire duc_pkg::sincos_t    i_sc,
  input  wire                 i_sc_valid,
  output logic                o_sc_ready,
  output duc_pkg::prod_beat_t o_prod,
  output logic                o_prod_valid,
  input  wire                 i_prod_ready
);

  import duc_pkg::*;

  // Sum of two full products needs one bit over the product width
  localparam int PROD_W = INPUT_W + DDS_W + 1;

  logic                     take;
  logic signed [PROD_W-1:0] smp_i;
  logic signed [PROD_W-1:0] smp_q;
  logic signed [PROD_W-1:0] sc_cos;
  logic signed [PROD_W-1:0] sc_sin;
  logic signed [PROD_W-1:0] mix_i;
  logic signed [PROD_W-1:0] mix_q;

  // A pair is taken only as a pair, which keeps sample n locked to phase n
  assign take        = i_smp_valid && i_sc_valid && (!o_prod_valid || i_prod_ready);
  assign o_smp_ready = take;
  assign o_sc_ready  = take;

  // --------------------------------------------------------------------------
  // Complex product
  // --------------------------------------------------------------------------

  always_comb begin
    // Operands are sign extended to the result width first, so no bits are lost
    smp_i  = PROD_W'(i_smp.iq.i);
    smp_q  = PROD_W'(i_smp.iq.q);
    sc_cos = PROD_W'(i_sc.cos);
    sc_sin = PROD_W'(i_sc.sin);
    // (I + jQ)(cos + j sin)
    mix_i  = smp_i * sc_cos - smp_q * sc_sin;
    mix_q  = smp_i * sc_sin + smp_q * sc_cos;
  end

  // Packet boundaries follow the sample stream, the phase side has none
  always_ff @(posedge clk) begin
    if (take) begin
      o_prod.i    <= mix_i;
      o_prod.q    <= mix_q;
      o_prod.last <= i_smp.last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_prod_valid <= 1'b0;
    end else if (take) begin
      o_prod_valid <= 1'b1;
    end else if (i_prod_ready) begin
      o_prod_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* dds_freq_tune_duc.sv */
`default_nettype none

module dds_freq_tune_duc #(
  parameter int INPUT_W  = duc_pkg::INPUT_W,
  parameter int PHASE_W  = duc_pkg::PHASE_W,
  parameter int OUTPUT_W = duc_pkg::OUTPUT_W
) (
  input  wire                 clk,
  input  wire                 i_rst,
  // Baseband samples, {Q,I}
  input  wire duc_pkg::iq_beat_t i_din,
  input  wire                 i_din_valid,
  output logic                o_din_ready,
  // Phase words from the NCO
  input  wire [PHASE_W-1:0]   i_phase,
  input  wire                 i_phase_last,
  input  wire                 i_phase_valid,
  output logic                o_phase_ready,
  // Shifted samples, {Q,I}
  output duc_pkg::iq_beat_t   o_dout,
  output logic                o_dout_valid,
  input  wire                 i_dout_ready
);

  import duc_pkg::*;

  localparam int FIFO_DEPTH = 4;
  localparam int PROD_W     = INPUT_W + DDS_W + 1;

  // --------------------------------------------------------------------------
  // Reset stretch
  // --------------------------------------------------------------------------

  logic rst_d1;
  logic rst_int;

  // Internal reset lasts at least two cycles, even for a one-cycle i_rst pulse
  always_ff @(posedge clk) begin
    rst_d1  <= i_rst;
    rst_int <= i_rst | rst_d1;
  end

  iq_beat_t   fifo_beat;
  logic       fifo_valid;
  logic       fifo_ready;
  sincos_t    sc;
  logic       sc_valid;
  logic       sc_ready;
  prod_beat_t prod;
  logic       prod_valid;
  logic       prod_ready;

  // Samples wait here while the table lookup for their phase is in flight
  sample_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) sample_fifo_i (
    .clk         (clk),
    .i_rst       (rst_int),
    .i_in        (i_din),
    .i_in_valid  (i_din_valid),
    .o_in_ready  (o_din_ready),
    .o_out       (fifo_beat),
    .o_out_valid (fifo_valid),
    .i_out_ready (fifo_ready)
  );

  // The DDS is never flushed between packets, i_phase_last does not reach it
  dds_sincos #(
    .PHASE_W  (PHASE_W),
    .DDS_W    (DDS_W),
    .LUT_BITS (LUT_BITS)
  ) dds_sincos_i (
    .clk           (clk),
    .i_rst         (rst_int),
    .i_phase       (i_phase),
    .i_phase_valid (i_phase_valid),
    .o_phase_ready (o_phase_ready),
    .o_sc          (sc),
    .o_sc_valid    (sc_valid),
    .i_sc_ready    (sc_ready)
  );

  complex_mixer #(
    .INPUT_W (INPUT_W),
    .DDS_W   (DDS_W)
  ) complex_mixer_i (
    .clk          (clk),
    .i_rst        (rst_int),
    .i_smp        (fifo_beat),
    .i_smp_valid  (fifo_valid),
    .o_smp_ready  (fifo_ready),
    .i_sc         (sc),
    .i_sc_valid   (sc_valid),
    .o_sc_ready   (sc_ready),
    .o_prod       (prod),
    .o_prod_valid (prod_valid),
    .i_prod_ready (prod_ready)
  );

  round_sat #(
    .MULT_W      (PROD_W),
    .OUTPUT_W    (OUTPUT_W),
    .ROUND_SHIFT (ROUND_SHIFT)
  ) round_sat_i (
    .clk          (clk),
    .i_rst        (rst_int),
    .i_prod       (prod),
    .i_prod_valid (prod_valid),
    .o_prod_ready (prod_ready),
    .o_out        (o_dout),
    .o_out_valid  (o_dout_valid),
    .i_out_ready  (i_dout_ready)
  );

  // The NCO must hold a stalled phase beat, its last flag included
  a_phase_held: assert property (@(posedge clk) disable iff (rst_int)
    (i_phase_valid && !o_phase_ready) |=> (i_phase_valid && $stable({i_phase_last, i_phase})));

endmodule

`default_nettype wire

/* dds_sincos.sv */
`default_nettype none

module dds_sincos #(
  parameter int PHASE_W  = duc_pkg::PHASE_W,
  parameter int DDS_W    = duc_pkg::DDS_W,
  parameter int LUT_BITS = duc_pkg::LUT_BITS
) (
  input  wire               clk,
  input  wire               i_rst,
  input  wire [PHASE_W-1:0] i_phase,
  input  wire               i_phase_valid,
  output logic              o_phase_ready,
  output duc_pkg::sincos_t  o_sc,
  output logic              o_sc_valid,
  input  wire               i_sc_ready
);

  import duc_pkg::*;

  localparam int LUT_SIZE = 2 ** LUT_BITS;

  // --------------------------------------------------------------------------
  // Sine table
  // --------------------------------------------------------------------------

  // Full-wave table, sin in the upper half of each word
  logic [2*DDS_W-1:0] lut [LUT_SIZE];

  // The table is constant and built once at elaboration, no quarter-wave folding
  initial begin
    for (int k = 0; k < LUT_SIZE; k++) begin
      lut[k] = sincos_entry(k, LUT_BITS);
    end
  end

  // --------------------------------------------------------------------------
  // Two-stage lookup pipeline
  // --------------------------------------------------------------------------

  logic [LUT_BITS-1:0] s1_idx;
  logic                s1_valid;
  logic                advance;

  // Both stages move together, whenever the output register can take a word
  assign advance       = !o_sc_valid || i_sc_ready;
  assign o_phase_ready = advance;

  // Stage 1 keeps only the table index, the low phase bits are dropped
  // Stage 2 is the registered table read
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_idx <= i_phase[PHASE_W-1 -: LUT_BITS];
      o_sc   <= lut[s1_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      s1_valid   <= 1'b0;
      o_sc_valid <= 1'b0;
    end else if (advance) begin
      s1_valid   <= i_phase_valid;
      o_sc_valid <= s1_valid;
    end
  end

  // A word offered downstream stays put until it is taken
  a_sc_stable: assert property (@(posedge clk) disable iff (i_rst)
    (o_sc_valid && !i_sc_ready) |=> (o_sc_valid && $stable(o_sc)));

endmodule

`default_nettype wire

/* duc_pkg.sv */
`default_nettype none

package duc_pkg;

  // --------------------------------------------------------------------------
  // Stream widths
  // --------------------------------------------------------------------------

  // One component of an input sample
  localparam int INPUT_W  = 24;
  // Phase word, unsigned, covering one full turn
  localparam int PHASE_W  = 24;
  // One component of an output sample
  localparam int OUTPUT_W = 24;
  // One component of the synthesized sinusoid
  localparam int DDS_W    = 16;
  // Phase bits that address the sine table
  localparam int LUT_BITS = 10;
  // Full-precision product, with one extra bit for the sum of two products
  localparam int MULT_W   = INPUT_W + DDS_W + 1;

  // --------------------------------------------------------------------------
  // Fixed-point positions
  // --------------------------------------------------------------------------

  localparam int IQ_FRAC     = 15;
  localparam int DDS_FRAC    = 14;
  localparam int MULT_FRAC   = IQ_FRAC + DDS_FRAC;
  // Rounding brings the product back to the sample fraction width
  localparam int ROUND_SHIFT = MULT_FRAC - IQ_FRAC;

  localparam real TWO_PI    = 6.283185307179586;
  localparam real DDS_SCALE = 2.0 ** DDS_FRAC;

  // Complex sample, Q in the upper half
  typedef struct packed {
    logic signed [INPUT_W-1:0] q;
    logic signed [INPUT_W-1:0] i;
  } iq_t;

  // Payload of the sample stream
  typedef struct packed {
    logic last;
    iq_t  iq;
  } iq_beat_t;

  // Unit-length sinusoid, sin in the upper half as the DDS core delivers it
  typedef struct packed {
    logic signed [DDS_W-1:0] sin;
    logic signed [DDS_W-1:0] cos;
  } sincos_t;

  // Product of one sample with one sinusoid, before rounding
  typedef struct packed {
    logic                     last;
    logic signed [MULT_W-1:0] q;
    logic signed [MULT_W-1:0] i;
  } prod_beat_t;

  typedef enum logic [1:0] {
    FIFO_EMPTY,
    FIFO_PARTIAL,
    FIFO_FULL
  } fifo_state_e;

  // One table entry, cos and sin of idx/2^lut_bits of a turn, rounded to nearest
  function automatic sincos_t sincos_entry(input int unsigned idx, input int unsigned lut_bits);
    real     angle;
    sincos_t entry;
    angle     = TWO_PI * real'(idx) / real'(2 ** lut_bits);
    entry.sin = DDS_W'(int'($floor($sin(angle) * DDS_SCALE + 0.5)));
    entry.cos = DDS_W'(int'($floor($cos(angle) * DDS_SCALE + 0.5)));
    return entry;
  endfunction

endpackage

`default_nettype wire

/* round_sat.sv */
`default_nettype none

module round_sat #(
  parameter int MULT_W      = duc_pkg::MULT_W,
  parameter int OUTPUT_W    = duc_pkg::OUTPUT_W,
  parameter int ROUND_SHIFT = duc_pkg::ROUND_SHIFT
) (
  input  wire                 clk,
  input  wire                 i_rst,
  input  wire duc_pkg::prod_beat_t i_prod,
  input  wire                 i_prod_valid,
  output logic                o_prod_ready,
  output duc_pkg::iq_beat_t   o_out,
  output logic                o_out_valid,
  input  wire                 i_out_ready
);

  import duc_pkg::*;

  // Half of the output LSB, as seen at the product's scale
  localparam logic signed [MULT_W:0] HALF_LSB = (MULT_W + 1)'(1) <<< (ROUND_SHIFT - 1);
  // Signed output range, extended to the working width
  localparam logic signed [MULT_W:0] OUT_MAX  = ((MULT_W + 1)'(1) <<< (OUTPUT_W - 1)) - 1;
  localparam logic signed [MULT_W:0] OUT_MIN  = -OUT_MAX - 1;

  logic load;

  // Round half up, then clamp whatever no longer fits
  function automatic logic signed [OUTPUT_W-1:0] round_comp(input logic signed [MULT_W-1:0] x);
    logic signed [MULT_W:0] biased;
    logic signed [MULT_W:0] shifted;
    // One guard bit so the bias can never wrap the sum
    biased  = $signed({x[MULT_W-1], x}) + HALF_LSB;
    shifted = biased >>> ROUND_SHIFT;
    if (shifted > OUT_MAX) begin
      return OUT_MAX[OUTPUT_W-1:0];
    end
    if (shifted < OUT_MIN) begin
      return OUT_MIN[OUTPUT_W-1:0];
    end
    return shifted[OUTPUT_W-1:0];
  endfunction

  assign o_prod_ready = !o_out_valid || i_out_ready;
  assign load         = i_prod_valid && o_prod_ready;

  always_ff @(posedge clk) begin
    if (load) begin
      o_out.iq.i <= round_comp(i_prod.i);
      o_out.iq.q <= round_comp(i_prod.q);
      o_out.last <= i_prod.last;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_out_valid <= 1'b0;
    end else if (o_prod_ready) begin
      o_out_valid <= i_prod_valid;
    end
  end

  // What the output port offers must not change until it is accepted
  a_out_stable: assert property (@(posedge clk) disable iff (i_rst)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out)));

endmodule

`default_nettype wire

/* sample_fifo.sv */
`default_nettype none

module sample_fifo #(
  parameter int DEPTH = 4
) (
  input  wire               clk,
  input  wire               i_rst,
  input  wire duc_pkg::iq_beat_t i_in,
  input  wire               i_in_valid,
  output logic              o_in_ready,
  output duc_pkg::iq_beat_t o_out,
  output logic              o_out_valid,
  input  wire               i_out_ready
);

  import duc_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage has no reset, only the pointers and occupancy do
  iq_beat_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  fifo_state_e      state;
  logic             wr_en;
  logic             rd_en;

  // Pointer advance that also works for depths other than a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Ready and valid come straight from the registered occupancy state
  assign o_in_ready  = (state != FIFO_FULL);
  assign o_out_valid = (state != FIFO_EMPTY);

  // The head entry is already in a register, so it falls through directly
  assign o_out = mem[rd_ptr];

  assign wr_en = i_in_valid && o_in_ready;
  assign rd_en = o_out_valid && i_out_ready;

  always_comb begin
    count_next = count;
    if (wr_en && !rd_en) begin
      count_next = count + 1'b1;
    end else if (rd_en && !wr_en) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_in;
    end
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      state  <= FIFO_EMPTY;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count_next;
      // Next state follows the next occupancy so the flags are never a cycle late
      if (count_next == '0) begin
        state <= FIFO_EMPTY;
      end else if (count_next == CNT_W'(DEPTH)) begin
        state <= FIFO_FULL;
      end else begin
        state <= FIFO_PARTIAL;
      end
    end
  end

  // The state encoding must agree with the counter on every transfer
  a_no_write_when_full: assert property (@(posedge clk) disable iff (i_rst)
    wr_en |-> (count != CNT_W'(DEPTH)));
  a_no_read_when_empty: assert property (@(posedge clk) disable iff (i_rst)
    rd_en |-> (count != '0));

endmodule

`default_nettype wire

/* duc_model.svh */
`ifndef DUC_MODEL_SVH
`define DUC_MODEL_SVH

// Table entry selected by the top phase bits
// Cos and sin of the index as a fraction of a turn, rounded to nearest at the DDS fraction width
function automatic duc_pkg::sincos_t model_sincos(input logic [duc_pkg::PHASE_W-1:0] phase);
  int unsigned      idx;
  real              angle;
  int               sin_val;
  int               cos_val;
  duc_pkg::sincos_t sc;
  idx     = int'(phase >> (duc_pkg::PHASE_W - duc_pkg::LUT_BITS));
  angle   = duc_pkg::TWO_PI * real'(idx) / real'(1 << duc_pkg::LUT_BITS);
  sin_val = $rtoi($floor($sin(angle) * duc_pkg::DDS_SCALE + 0.5));
  cos_val = $rtoi($floor($cos(angle) * duc_pkg::DDS_SCALE + 0.5));
  sc.sin  = sin_val[duc_pkg::DDS_W-1:0];
  sc.cos  = cos_val[duc_pkg::DDS_W-1:0];
  return sc;
endfunction

// Round half up by ROUND_SHIFT bits and clamp to the output range
function automatic logic signed [duc_pkg::OUTPUT_W-1:0] model_round_sat(input longint acc);
  longint                             out_max;
  longint                             out_min;
  longint                             shifted;
  logic signed [duc_pkg::OUTPUT_W-1:0] res;
  out_max = (longint'(1) <<< (duc_pkg::OUTPUT_W - 1)) - 1;
  out_min = -out_max - 1;
  shifted = (acc + (longint'(1) <<< (duc_pkg::ROUND_SHIFT - 1))) >>> duc_pkg::ROUND_SHIFT;
  if (shifted > out_max) begin
    shifted = out_max;
  end else if (shifted < out_min) begin
    shifted = out_min;
  end
  res = shifted[duc_pkg::OUTPUT_W-1:0];
  return res;
endfunction

// Expected output sample for one sample and phase pair
function automatic duc_pkg::iq_t model_duc(input duc_pkg::iq_t smp,
                                           input logic [duc_pkg::PHASE_W-1:0] phase);
  duc_pkg::sincos_t sc;
  duc_pkg::iq_t     res;
  longint           acc_i;
  longint           acc_q;
  sc    = model_sincos(phase);
  acc_i = longint'(smp.i) * longint'(sc.cos) - longint'(smp.q) * longint'(sc.sin);
  acc_q = longint'(smp.i) * longint'(sc.sin) + longint'(smp.q) * longint'(sc.cos);
  res.i = model_round_sat(acc_i);
  res.q = model_round_sat(acc_q);
  return res;
endfunction

`endif

/* tb_duc.sv */
`default_nettype none

module tb_duc;

  import duc_pkg::*;

  `include "duc_model.svh"

  // --------------------------------------------------------------------------
  // Run length and limits
  // --------------------------------------------------------------------------

  localparam int N_RAND  = 300;
  localparam int N_BP    = 300;
  localparam int N_SAT   = 32;
  localparam int N_ZERO  = 64;
  localparam int MAX_GAP = 3;
  localparam int TOTAL_BEATS = N_RAND + N_BP + N_SAT + N_ZERO;
  // Each beat costs at most its input gap plus one cycle, back-pressure roughly doubles that
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * (MAX_GAP + 1) * 4 + 500;

  localparam logic signed [INPUT_W-1:0]  FS_POS = {1'b0, {(INPUT_W-1){1'b1}}};
  localparam logic signed [INPUT_W-1:0]  FS_NEG = {1'b1, {(INPUT_W-1){1'b0}}};
  localparam logic signed [OUTPUT_W-1:0] SAT_HI = {1'b0, {(OUTPUT_W-1){1'b1}}};
  localparam logic signed [OUTPUT_W-1:0] SAT_LO = {1'b1, {(OUTPUT_W-1){1'b0}}};

  logic               clk;
  logic               rst;
  iq_beat_t           din;
  logic               din_valid;
  logic               din_ready;
  logic [PHASE_W-1:0] phase;
  logic               phase_last;
  logic               phase_valid;
  logic               phase_ready;
  iq_beat_t           dout;
  logic               dout_valid;
  logic               dout_ready;

  logic               bp_enable;
  string              test_name;
  int                 n_out;
  int                 n_planned;
  int                 sat_seen;
  logic               held;
  iq_beat_t           held_beat;

  // Beats still to be driven, and beats the DUT has accepted but not yet returned
  iq_beat_t           din_plan[$];
  logic [PHASE_W:0]   ph_plan[$];
  iq_beat_t           din_acc[$];
  logic [PHASE_W-1:0] ph_acc[$];

  dds_freq_tune_duc #(
    .INPUT_W  (INPUT_W),
    .PHASE_W  (PHASE_W),
    .OUTPUT_W (OUTPUT_W)
  ) dds_freq_tune_duc_i (
    .clk           (clk),
    .i_rst         (rst),
    .i_din         (din),
    .i_din_valid   (din_valid),
    .o_din_ready   (din_ready),
    .i_phase       (phase),
    .i_phase_last  (phase_last),
    .i_phase_valid (phase_valid),
    .o_phase_ready (phase_ready),
    .o_dout        (dout),
    .o_dout_valid  (dout_valid),
    .i_dout_ready  (dout_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Error handling
  // --------------------------------------------------------------------------

  task automatic report_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      report_error($sformatf("[FAIL] %s %s: expected 'h%0h, actual 'h%0h",
                             test_name, what, exp, act));
    end
  endtask

  // --------------------------------------------------------------------------
  // Monitor and scoreboard
  // --------------------------------------------------------------------------

  // Runs on every rising edge, before the DUT registers take their new values
  task automatic watch_cycle();
    iq_beat_t           exp_smp;
    logic [PHASE_W-1:0] exp_ph;
    iq_t                exp_iq;
    // A beat refused on the last edge must still be offered unchanged
    if (held) begin
      check_value("dout_valid while stalled", 1'b1, dout_valid);
      check_value("dout while stalled", held_beat, dout);
    end
    held      = dout_valid && !dout_ready;
    held_beat = dout;
    if (din_valid && din_ready) begin
      din_acc.push_back(din);
    end
    if (phase_valid && phase_ready) begin
      ph_acc.push_back(phase);
    end
    if (dout_valid && dout_ready) begin
      if (din_acc.size() == 0 || ph_acc.size() == 0) begin
        report_error("Output beat appeared with no matching sample and phase accepted");
      end else begin
        exp_smp = din_acc.pop_front();
        exp_ph  = ph_acc.pop_front();
        exp_iq  = model_duc(exp_smp.iq, exp_ph);
        check_value("dout.iq", exp_iq, dout.iq);
        check_value("dout.last", exp_smp.last, dout.last);
        // Table index zero is cos 16384 and sin 0, which is an exact identity
        if (exp_ph[PHASE_W-1 -: LUT_BITS] == '0) begin
          check_value("zero phase identity", exp_smp.iq, dout.iq);
        end
        // Full-scale corners at an odd eighth of a turn reach a rail only through clamping
        if (exp_ph[PHASE_W-3] && (dout.iq.i == SAT_HI || dout.iq.i == SAT_LO ||
            dout.iq.q == SAT_HI || dout.iq.q == SAT_LO)) begin
          sat_seen++;
        end
        n_out++;
      end
    end
  endtask

  initial begin
    held  = 1'b0;
    n_out = 0;
    forever begin
      @(posedge clk);
      if (!rst) begin
        watch_cycle();
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // Random low periods on the output side while back-pressure is enabled
  initial begin
    dout_ready = 1'b1;
    forever begin
      @(negedge clk);
      if (bp_enable) begin
        dout_ready <= ($urandom_range(9, 0) >= 4);
      end else begin
        dout_ready <= 1'b1;
      end
    end
  end

  task automatic drive_din(input int max_gap);
    int gap;
    while (din_plan.size() != 0) begin
      gap = $urandom_range(max_gap, 0);
      if (gap != 0) begin
        din_valid <= 1'b0;
        repeat (gap) @(negedge clk);
      end
      din       <= din_plan.pop_front();
      din_valid <= 1'b1;
      @(posedge clk);
      while (!din_ready) @(posedge clk);
      @(negedge clk);
    end
    din_valid <= 1'b0;
  endtask

  // The phase last flag is randomized too and held with its word while stalled
  task automatic drive_phase(input int max_gap);
    int gap;
    while (ph_plan.size() != 0) begin
      gap = $urandom_range(max_gap, 0);
      if (gap != 0) begin
        phase_valid <= 1'b0;
        repeat (gap) @(negedge clk);
      end
      {phase_last, phase} <= ph_plan.pop_front();
      phase_valid <= 1'b1;
      @(posedge clk);
      while (!phase_ready) @(posedge clk);
      @(negedge clk);
    end
    phase_valid <= 1'b0;
  endtask

  task automatic plan_beat(input iq_t smp, input logic [PHASE_W-1:0] ph);
    iq_beat_t beat;
    beat.iq   = smp;
    beat.last = ($urandom_range(7, 0) == 0);
    din_plan.push_back(beat);
    ph_plan.push_back({1'($urandom_range(1, 0)), ph});
  endtask

  task automatic plan_random(input int n, input bit zero_phase);
    iq_t smp;
    for (int k = 0; k < n; k++) begin
      smp.i = INPUT_W'($urandom());
      smp.q = INPUT_W'($urandom());
      plan_beat(smp, zero_phase ? '0 : PHASE_W'($urandom()));
    end
  endtask

  // Four full-scale corners at each eighth of a turn, low phase bits random
  task automatic plan_saturation();
    iq_t smp;
    for (int k = 0; k < 8; k++) begin
      for (int c = 0; c < 4; c++) begin
        smp.i = c[0] ? FS_NEG : FS_POS;
        smp.q = c[1] ? FS_NEG : FS_POS;
        plan_beat(smp, (PHASE_W'(k) << (PHASE_W - 3)) | PHASE_W'($urandom_range(2**20, 0)));
      end
    end
  endtask

  // Drives the planned beats and waits until every one has come back
  task automatic run_stream(input int max_gap);
    n_planned += din_plan.size();
    @(negedge clk);
    fork
      drive_din(max_gap);
      drive_phase(max_gap);
    join
    while (n_out < n_planned) @(posedge clk);
    @(negedge clk);
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_error($sformatf("Timeout: the run did not finish within %0d cycles",
                           WATCHDOG_CYCLES));
  end

  initial begin
    void'($urandom(32'hbd7));
    rst         = 1'b1;
    din         = '0;
    din_valid   = 1'b0;
    phase       = '0;
    phase_last  = 1'b0;
    phase_valid = 1'b0;
    bp_enable   = 1'b0;
    n_planned   = 0;
    sat_seen    = 0;
    test_name   = "reset";
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Let the stretched internal reset run out before looking
    repeat (3) @(negedge clk);
    check_value("dout_valid after reset", 1'b0, dout_valid);
    check_value("din_ready after reset", 1'b1, din_ready);
    check_value("phase_ready after reset", 1'b1, phase_ready);

    test_name = "random_stream";
    plan_random(N_RAND, 1'b0);
    run_stream(MAX_GAP);

    test_name = "back_pressure";
    bp_enable = 1'b1;
    plan_random(N_BP, 1'b0);
    run_stream(1);
    bp_enable = 1'b0;

    test_name = "saturation";
    sat_seen  = 0;
    plan_saturation();
    run_stream(0);
    check_value("saturated outputs seen", 1'b1, sat_seen != 0);

    test_name = "phase_zero";
    plan_random(N_ZERO, 1'b1);
    run_stream(MAX_GAP);

    // Quiet tail, any stray output beat is caught by the monitor
    repeat (10) @(negedge clk);
    if (n_out == TOTAL_BEATS && din_acc.size() == 0 && ph_acc.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      report_error($sformatf("Beat count mismatch at the end: %0d of %0d outputs received",
                             n_out, TOTAL_BEATS));
    end
  end

endmodule

`default_nettype wire
